// File: qspi_cmd_decode.sv
module qspi_cmd_decode
	import qspi_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  cmd_t  cmd_i,
	input  logic  cmd_valid_i,
	output logic  cmd_ready_o,
	input  logic  cmd_take_i,   // sequencer took the slot
	output cmd_t  cur_cmd_o,
	output byte_t shift_word_o, // data in lane order
	output beat_t beats_o,      // sclk beats for the phase
	output logic  pending_o
);

	logic  slot_valid;
	byte_t d;
	byte_t word_d;
	beat_t beats_d;

	assign d = cmd_i.data;

	// lane order: dq3 takes bit 7, dq2 bit 5, dq1 bit 3, dq0 bit 1
	// and the word shifts left by one per beat
	always_comb
	begin
		case (cmd_i.mode)
			mode_dual: word_d = {d[7], d[5], d[3], d[1], d[6], d[4], d[2], d[0]};
			mode_quad: word_d = {d[7], d[3], d[6], d[2], d[5], d[1], d[4], d[0]};
			default:   word_d = d; // single, msb first on dq0
		endcase
	end

	// beats per phase
	always_comb
	begin
		if (cmd_i.op == op_dummy)
			beats_d = beat_t'(cmd_i.dummy_clks);
		else
		begin
			case (cmd_i.mode)
				mode_dual: beats_d = beat_t'(4);
				mode_quad: beats_d = beat_t'(2);
				default:   beats_d = beat_t'(8);
			endcase
		end
	end

	// ----------------------------------------
	// single command slot
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			slot_valid <= 1'b0;
		else if (cmd_valid_i && cmd_ready_o)
			slot_valid <= 1'b1;
		else if (cmd_take_i)
			slot_valid <= 1'b0; // free again
	end

	always_ff @(posedge clk)
	begin
		if (cmd_valid_i && cmd_ready_o)
		begin
			cur_cmd_o    <= cmd_i;
			shift_word_o <= word_d;
			beats_o      <= beats_d;
		end
	end

	assign cmd_ready_o = !slot_valid; // ready while empty
	assign pending_o   = slot_valid;

endmodule

// File: qspi_engine.sv
module qspi_engine
	import qspi_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  div_t   div_i,       // constant while select is low
	input  cmd_t   cmd_i,
	input  logic   cmd_valid_i,
	output logic   cmd_ready_o,
	output byte_t  rd_data_o,
	output logic   rd_valid_o,
	input  logic   rd_ready_i,
	output logic   sclk_o,
	output logic   sel_n_o,
	output lanes_t dq_o,
	output lanes_t dq_oe_o,
	input  lanes_t dq_i
);

	cmd_t       cur_cmd;
	byte_t      shift_word;
	beat_t      beats;
	logic       cmd_pending;
	logic       cmd_take;
	logic       run;
	logic       rise;
	logic       fall;
	logic       sample;
	logic       rd_done;
	logic       slot_free;
	lane_mode_e rd_mode;

	// ----------------------------------------
	// command slot, clock, FSM, read path
	// ----------------------------------------
	qspi_cmd_decode u_decode (
		.clk(clk), .reset(reset),
		.cmd_i(cmd_i), .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o),
		.cmd_take_i(cmd_take), .cur_cmd_o(cur_cmd), .shift_word_o(shift_word),
		.beats_o(beats), .pending_o(cmd_pending)
	);

	qspi_sclk_gen u_sclk (
		.clk(clk), .reset(reset), .div_i(div_i), .run_i(run),
		.rise_o(rise), .fall_o(fall), .sclk_o(sclk_o)
	);

	qspi_sequencer u_seq (
		.clk(clk), .reset(reset), .rise_i(rise), .fall_i(fall),
		.cur_cmd_i(cur_cmd), .shift_word_i(shift_word), .beats_i(beats),
		.pending_i(cmd_pending), .slot_free_i(slot_free), .cmd_take_o(cmd_take),
		.run_o(run), .sample_o(sample), .rd_done_o(rd_done), .mode_o(rd_mode),
		.sel_n_o(sel_n_o), .dq_o(dq_o), .dq_oe_o(dq_oe_o)
	);

	qspi_read_assemble u_rd (
		.clk(clk), .reset(reset), .mode_i(rd_mode), .sample_i(sample),
		.rd_done_i(rd_done), .dq_i(dq_i), .slot_free_o(slot_free),
		.rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o), .rd_ready_i(rd_ready_i)
	);

endmodule

// File: qspi_pkg.sv
`include "qspi_settings.svh"

package qspi_pkg;

	// ----------------------------------------
	// plain vectors
	// ----------------------------------------
	typedef logic [`QSPI_DIV_W-1:0]   div_t;   // clk cycles per sclk period
	typedef logic [`QSPI_BYTE_W-1:0]  byte_t;
	typedef logic [`QSPI_LANES-1:0]   lanes_t; // one bit per dq lane
	typedef logic [3:0]               beat_t;  // sclk beats left in a phase
	typedef logic [`QSPI_DUMMY_W-1:0] dummy_t;

	// lanes used per beat
	typedef enum logic [1:0]
	{
		mode_single = 2'd0, // dq0 out, dq1 in
		mode_dual   = 2'd1,
		mode_quad   = 2'd2
	} lane_mode_e;

	typedef enum logic [1:0]
	{
		op_write = 2'd0,
		op_read  = 2'd1,
		op_dummy = 2'd2  // clocks only, lanes released
	} cmd_op_e;

	// one queued command, 17 bits
	typedef struct packed
	{
		cmd_op_e    op;
		lane_mode_e mode;
		byte_t      data;       // write data, ignored otherwise
		dummy_t     dummy_clks; // dummy phase length
		logic       last;       // release select after this one
	} cmd_t;

	typedef enum logic [2:0]
	{
		st_idle   = 3'd0,
		st_dummy  = 3'd1,
		st_send   = 3'd2,
		st_read   = 3'd3,
		st_finish = 3'd4
	} seq_state_e;

endpackage

// File: qspi_read_assemble.sv
module qspi_read_assemble
	import qspi_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  lane_mode_e mode_i,
	input  logic       sample_i,   // read rising edge
	input  logic       rd_done_i,  // last sample of the byte
	input  lanes_t     dq_i,
	output logic       slot_free_o,
	output byte_t      rd_data_o,
	output logic       rd_valid_o,
	input  logic       rd_ready_i
);

	byte_t sh_q; // bits collected so far
	byte_t sh_d; // with the current sample

	// msb first per mode, dq1 alone in single mode
	always_comb
	begin
		case (mode_i)
			mode_dual: sh_d = {sh_q[5:0], dq_i[1:0]};  // dq1 odd, dq0 even bits
			mode_quad: sh_d = {sh_q[3:0], dq_i[3:0]};  // upper nibble first
			default:   sh_d = {sh_q[6:0], dq_i[1]};
		endcase
	end

	// ----------------------------------------
	// lane shift and result register
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (sample_i)
			sh_q <= sh_d;
		if (rd_done_i)
			rd_data_o <= sh_d; // includes the final sample
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_valid_o <= 1'b0;
		else if (rd_done_i)
			rd_valid_o <= 1'b1;
		else if (rd_ready_i)
			rd_valid_o <= 1'b0; // accepted
	end

	// sequencer holds off reads while a result waits
	assign slot_free_o = !rd_valid_o;

endmodule

// File: qspi_sclk_gen.sv
module qspi_sclk_gen
	import qspi_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  div_t div_i,   // full sclk period in clk cycles
	input  logic run_i,   // from sequencer
	output logic rise_o,  // sclk goes high on this clk edge
	output logic fall_o,  // sclk goes low on this clk edge
	output logic sclk_o
);

	div_t cnt;      // position inside the sclk period
	div_t last_cnt; // wrap point
	div_t half_cnt; // start of the high half

	assign last_cnt = div_i - div_t'(1);
	assign half_cnt = div_i >> 1;

	// strobes only while running
	assign fall_o = run_i && (cnt == '0);
	assign rise_o = run_i && (cnt == half_cnt);

	// ----------------------------------------
	// period counter and sclk register
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt    <= '0;
			sclk_o <= 1'b1; // idle high
		end
		else if (!run_i)
		begin
			cnt    <= '0;   // next run starts with a fall
			sclk_o <= 1'b1;
		end
		else
		begin
			if (cnt == last_cnt)
				cnt <= '0;
			else
				cnt <= cnt + div_t'(1);
			if (fall_o)
				sclk_o <= 1'b0; // low half
			else if (rise_o)
				sclk_o <= 1'b1; // high half
		end
	end

endmodule

// File: qspi_sequencer.sv
module qspi_sequencer
	import qspi_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rise_i,
	input  logic       fall_i,
	input  cmd_t       cur_cmd_i,
	input  byte_t      shift_word_i,
	input  beat_t      beats_i,
	input  logic       pending_i,
	input  logic       slot_free_i,  // result register empty
	output logic       cmd_take_o,
	output logic       run_o,        // sclk enable
	output logic       sample_o,
	output logic       rd_done_o,
	output lane_mode_e mode_o,
	output logic       sel_n_o,
	output lanes_t     dq_o,
	output lanes_t     dq_oe_o
);

	seq_state_e state;
	cmd_t       act_cmd;  // command on the bus
	byte_t      sh_q;     // remaining write bits
	beat_t      beat_cnt;
	logic       done_q;   // all beats of the phase seen
	logic       gap_q;    // one idle cycle after a frame
	logic       busy;
	logic       start_ok;
	logic       take;
	logic       shift_en;

	// lane bits for the next beat
	function automatic lanes_t lane_bits(input byte_t w, input lane_mode_e m);
		lanes_t l;
		case (m)
			mode_dual: l = {2'b00, w[7], w[3]};
			mode_quad: l = {w[7], w[5], w[3], w[1]};
			default:   l = {3'b000, w[7]};
		endcase
		return l;
	endfunction

	function automatic lanes_t lane_mask(input lane_mode_e m);
		lanes_t l;
		case (m)
			mode_dual: l = 4'b0011;
			mode_quad: l = 4'b1111;
			default:   l = 4'b0001;
		endcase
		return l;
	endfunction

	assign busy     = (state == st_dummy) || (state == st_send) || (state == st_read);
	// a read needs a free result slot
	assign start_ok = pending_i && ((cur_cmd_i.op != op_read) || slot_free_i);
	assign take     = fall_i && start_ok &&
		((state == st_idle) || (busy && done_q && !act_cmd.last));

	assign shift_en  = fall_i && (state == st_send) && !done_q;
	assign sample_o  = rise_i && (state == st_read) && !done_q;
	assign rd_done_o = sample_o && (beat_cnt == beat_t'(1)); // final sample
	assign cmd_take_o = take;
	assign mode_o     = act_cmd.mode;

	// sclk runs unless the frame waits for a command
	always_comb
	begin
		case (state)
			st_idle:   run_o = start_ok && !gap_q;
			st_finish: run_o = 1'b1; // keeps sclk low until select is up
			default:   run_o = !(done_q && !act_cmd.last && !start_ok);
		endcase
	end

	// ----------------------------------------
	// active command and shift word
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			act_cmd <= cur_cmd_i;
			sh_q    <= shift_word_i << 1; // first beat goes out now
		end
		else if (shift_en)
			sh_q <= sh_q << 1;
	end

	// ----------------------------------------
	// phase FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= st_idle;
			sel_n_o  <= 1'b1;
			dq_o     <= '0;
			dq_oe_o  <= '0;
			beat_cnt <= '0;
			done_q   <= 1'b0;
			gap_q    <= 1'b0;
		end
		else
		begin
			gap_q <= (state == st_finish);
			if (take)
			begin
				sel_n_o  <= 1'b0; // opens or continues the frame
				beat_cnt <= beats_i;
				done_q   <= 1'b0;
				case (cur_cmd_i.op)
					op_write:
					begin
						state   <= st_send;
						dq_o    <= lane_bits(shift_word_i, cur_cmd_i.mode);
						dq_oe_o <= lane_mask(cur_cmd_i.mode);
					end
					op_read:
					begin
						state   <= st_read;
						dq_o    <= '0;
						dq_oe_o <= '0; // flash drives
					end
					default:
					begin
						state   <= st_dummy;
						dq_o    <= '0;
						dq_oe_o <= '0;
					end
				endcase
			end
			else if (busy && fall_i && done_q && act_cmd.last)
			begin
				state   <= st_finish; // ends on this fall
				dq_o    <= '0;
				dq_oe_o <= '0;
			end
			else if (shift_en)
				dq_o <= lane_bits(sh_q, act_cmd.mode); // next beat after the fall
			else if (busy && rise_i && !done_q)
			begin
				beat_cnt <= beat_cnt - beat_t'(1);
				done_q   <= (beat_cnt == beat_t'(1));
			end
			else if (state == st_finish)
			begin
				sel_n_o <= 1'b1;
				state   <= st_idle;
			end
		end
	end

endmodule

// File: qspi_settings.svh
`ifndef QSPI_SETTINGS_SVH
`define QSPI_SETTINGS_SVH

// ----------------------------------------
// engine widths
// ----------------------------------------

// clk cycles per sclk period, even and >= 4
`define QSPI_DIV_W 13

// dq0..dq3
`define QSPI_LANES 4

`define QSPI_BYTE_W 8 // one transfer per command

// dummy clock count, up to 15 clocks
`define QSPI_DUMMY_W 4

`endif

// File: tb_clock_gen.sv
module tb_clock_gen #(
	parameter int period       = 4,
	parameter int reset_cycles = 3
)
(
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #(period / 2) clk_o = ~clk_o;
	end

	// reset held over the first rising edges, released on a falling edge
	initial
	begin
		reset_o = 1'b1;
		repeat (reset_cycles) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// File: tb_flash_model.sv
module tb_flash_model
	import qspi_pkg::*;
(
	input  logic        sclk_i,
	input  logic        sel_n_i,
	input  lanes_t      dq_i,        // lanes from the DUT
	input  lanes_t      dq_oe_i,
	input  lane_mode_e  mode_i,      // read lane mode
	input  int          skip_i,      // dummy beats before read data
	input  byte_t       rd_byte_a_i, // first read byte of a frame
	input  byte_t       rd_byte_b_i, // second one
	output lanes_t      dq_o,        // lanes to the DUT
	output logic [31:0] wr_log_o,    // captured write beats, newest low
	output int          wr_beats_o
);

	int   in_beats = 0; // beats with the DUT lanes released
	logic fresh    = 1'b1;

	// lanes for read beat j of the frame, msb first
	function automatic lanes_t read_lanes(input int j);
		int    per;
		int    n;
		byte_t v;
		per = (mode_i == mode_quad) ? 4 : ((mode_i == mode_dual) ? 2 : 1);
		n   = 8 / per;
		if (j < 0 || j >= 2 * n)
			return '0; // dummy beats
		v = ((j < n) ? rd_byte_a_i : rd_byte_b_i) >> (8 - per * (j % n + 1));
		case (mode_i)
			mode_quad: return v[3:0];
			mode_dual: return {2'b00, v[1:0]};   // dq1 odd bits
			default:   return {2'b00, v[0], 1'b0}; // single answers on dq1
		endcase
	endfunction

	initial
		dq_o = '0;

	always @(posedge sel_n_i)
	begin
		in_beats = 0; // frame over
		fresh    = 1'b1;
	end

	// rising edge, capture or count
	always @(posedge sclk_i)
	begin
		if (!sel_n_i)
		begin
			if (fresh)
			begin
				wr_log_o   = '0;
				wr_beats_o = 0;
				fresh      = 1'b0;
			end
			if (dq_oe_i != '0)
			begin
				wr_log_o   = {wr_log_o[27:0], dq_i};
				wr_beats_o = wr_beats_o + 1;
			end
			else
				in_beats = in_beats + 1;
		end
	end

	always @(negedge sclk_i)
		dq_o = read_lanes(in_beats - skip_i); // new bits after the fall

endmodule

// File: tb_qspi_engine.sv
module tb_qspi_engine
	import qspi_pkg::*;
();

	localparam int clk_period = 4;
	localparam int num_tests  = 5;
	localparam int timeout    = num_tests * 200 * 8 * clk_period; // 200 sclk at div 8

	logic        clk;
	logic        reset;
	div_t        div_i;
	cmd_t        cmd_i;
	logic        cmd_valid_i;
	logic        cmd_ready_o;
	byte_t       rd_data_o;
	logic        rd_valid_o;
	logic        rd_ready_i;
	logic        sclk_o;
	logic        sel_n_o;
	lanes_t      dq_o;
	lanes_t      dq_oe_o;
	lanes_t      dq_i;
	lane_mode_e  fm_mode;  // flash model read setup
	int          fm_skip;
	byte_t       fm_byte_a;
	byte_t       fm_byte_b;
	logic [31:0] wr_log;
	int          wr_beats;
	int          edge_cnt;  // sclk rises with select low
	lanes_t      oe_seen;   // lanes enabled on those rises
	int          sel_rises;

	tb_clock_gen #(.period(clk_period), .reset_cycles(3)) clk_gen (
		.clk_o(clk), .reset_o(reset)
	);

	qspi_engine uut (
		.clk(clk), .reset(reset), .div_i(div_i), .cmd_i(cmd_i),
		.cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o),
		.rd_data_o(rd_data_o), .rd_valid_o(rd_valid_o), .rd_ready_i(rd_ready_i),
		.sclk_o(sclk_o), .sel_n_o(sel_n_o), .dq_o(dq_o), .dq_oe_o(dq_oe_o), .dq_i(dq_i)
	);

	tb_flash_model flash (
		.sclk_i(sclk_o), .sel_n_i(sel_n_o), .dq_i(dq_o), .dq_oe_i(dq_oe_o),
		.mode_i(fm_mode), .skip_i(fm_skip), .rd_byte_a_i(fm_byte_a),
		.rd_byte_b_i(fm_byte_b), .dq_o(dq_i), .wr_log_o(wr_log), .wr_beats_o(wr_beats)
	);

	always @(posedge sclk_o)
		if (!sel_n_o)
		begin
			edge_cnt = edge_cnt + 1;
			oe_seen  = oe_seen | dq_oe_o; // lanes driven by the DUT
		end

	always @(posedge sel_n_o)
		sel_rises = sel_rises + 1;

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			$display("Errors found");
			$fatal(1, "check mismatch");
		end
	endtask

	// beats per byte, 1, 2 or 4 bits each
	function automatic int beats_for(input lane_mode_e m);
		return (m == mode_quad) ? 2 : ((m == mode_dual) ? 4 : 8);
	endfunction

	// byte from captured beats, first beat holds the top bits
	function automatic byte_t rebuild_byte(input logic [31:0] log, input int n,
		input lane_mode_e m);
		byte_t  b;
		lanes_t l;
		b = '0;
		for (int k = 0; k < n; k++)
		begin
			l = log[4 * (n - 1 - k) +: 4];
			case (m)
				mode_quad: b = {b[3:0], l};
				mode_dual: b = {b[5:0], l[1], l[0]}; // dq1 then dq0
				default:   b = {b[6:0], l[0]};
			endcase
		end
		return b;
	endfunction

	task automatic push_cmd(input cmd_op_e op, input lane_mode_e m, input byte_t d,
		input dummy_t n, input logic last);
		cmd_t c;
		c.op         = op;
		c.mode       = m;
		c.data       = d;
		c.dummy_clks = n;
		c.last       = last;
		@(negedge clk);
		cmd_i       = c;
		cmd_valid_i = 1'b1;
		while (!cmd_ready_o)
			@(negedge clk);
		@(negedge clk); // transfer on the edge just passed
		cmd_valid_i = 1'b0;
	endtask

	task automatic wait_frame_end();
		while (sel_n_o)
			@(negedge clk);
		while (!sel_n_o)
			@(negedge clk);
	endtask

	// wait for a result, check it and accept it for one cycle
	task automatic take_result(input string name, input byte_t exp);
		while (!rd_valid_o)
			@(negedge clk);
		compare_value(name, exp, rd_data_o);
		rd_ready_i = 1'b1;
		@(negedge clk);
		rd_ready_i = 1'b0;
	endtask

	task automatic write_frame(input string name, input lane_mode_e m);
		byte_t d;
		d        = byte_t'($urandom);
		edge_cnt = 0;
		oe_seen  = '0;
		push_cmd(op_write, m, d, '0, 1'b1);
		wait_frame_end();
		compare_value({name, " data"}, d, rebuild_byte(wr_log, wr_beats, m));
		compare_value({name, " edges"}, beats_for(m), edge_cnt);
		// one low bit per lane in use
		compare_value({name, " lanes"}, (1 << (8 / beats_for(m))) - 1, oe_seen);
	endtask

	task automatic read_frame(input string name, input lane_mode_e m);
		byte_t d;
		d = byte_t'($urandom);
		@(negedge clk);
		fm_mode   = m;
		fm_skip   = 0;
		fm_byte_a = d;
		fm_byte_b = ~d;
		edge_cnt  = 0;
		oe_seen   = '0;
		push_cmd(op_read, m, '0, '0, 1'b1);
		take_result({name, " data"}, d);
		while (!sel_n_o)
			@(negedge clk);
		compare_value({name, " edges"}, beats_for(m), edge_cnt);
		compare_value({name, " lanes"}, 0, oe_seen); // flash owns the lanes
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic multi_lane_writes();
		for (int i = 0; i < 2; i++)
		begin
			@(negedge clk);
			div_i = (i == 0) ? div_t'(4) : div_t'(8); // only between frames
			write_frame("dual write", mode_dual);
			write_frame("quad write", mode_quad);
		end
	endtask

	task automatic chained_frame();
		byte_t wd;
		byte_t rd;
		wd = byte_t'($urandom);
		rd = byte_t'($urandom);
		@(negedge clk);
		fm_mode   = mode_quad;
		fm_skip   = 5; // read data after the dummy clocks
		fm_byte_a = rd;
		edge_cnt  = 0;
		sel_rises = 0;
		push_cmd(op_write, mode_single, wd, '0, 1'b0);
		push_cmd(op_dummy, mode_single, '0, dummy_t'(5), 1'b0);
		push_cmd(op_read, mode_quad, '0, '0, 1'b1);
		take_result("chain read", rd);
		while (!sel_n_o)
			@(negedge clk);
		compare_value("chain write", wd, rebuild_byte(wr_log, wr_beats, mode_single));
		compare_value("chain edges", 8 + 5 + 2, edge_cnt);
		compare_value("chain select", 1, sel_rises);
	endtask

	task automatic stalled_reads();
		byte_t a;
		byte_t b;
		a = byte_t'($urandom);
		b = byte_t'($urandom);
		@(negedge clk);
		fm_mode   = mode_dual;
		fm_skip   = 0;
		fm_byte_a = a;
		fm_byte_b = b;
		edge_cnt  = 0;
		push_cmd(op_read, mode_dual, '0, '0, 1'b0);
		push_cmd(op_read, mode_dual, '0, '0, 1'b1);
		while (!rd_valid_o)
			@(negedge clk);
		repeat (4 * int'(div_i)) @(negedge clk); // result left waiting
		compare_value("stall edges", 4, edge_cnt);
		compare_value("stall select", 0, sel_n_o);
		take_result("stall first", a);
		take_result("stall second", b);
		while (!sel_n_o)
			@(negedge clk);
		compare_value("stall total edges", 8, edge_cnt);
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial
	begin
		void'($urandom(32'he1f1d3f0)); // one seed for the whole run
		div_i       = div_t'(8);
		cmd_i       = '0;
		cmd_valid_i = 1'b0;
		rd_ready_i  = 1'b0;
		fm_mode     = mode_single;
		fm_skip     = 0;
		fm_byte_a   = '0;
		fm_byte_b   = '0;
		edge_cnt    = 0;
		oe_seen     = '0;
		sel_rises   = 0;
		@(negedge reset);
		@(negedge clk);
		compare_value("reset select", 1, sel_n_o);
		compare_value("reset ready", 1, cmd_ready_o);
		compare_value("reset sclk", 1, sclk_o);
		compare_value("reset valid", 0, rd_valid_o);
		compare_value("reset dq", 0, dq_o);
		compare_value("reset dq enable", 0, dq_oe_o);
		write_frame("single write", mode_single);
		multi_lane_writes();
		read_frame("single read", mode_single);
		read_frame("dual read", mode_dual);
		read_frame("quad read", mode_quad);
		chained_frame();
		stalled_reads();
		$display("No errors");
		$finish;
	end

	initial
	begin
		#(timeout);
		$display("Errors found");
		$fatal(1, "timeout, the engine stopped responding");
	end

endmodule

// File: vlog.f
+incdir+.
qspi_pkg.sv
qspi_sclk_gen.sv
qspi_cmd_decode.sv
qspi_sequencer.sv
qspi_read_assemble.sv
qspi_engine.sv
tb_clock_gen.sv
tb_flash_model.sv
tb_qspi_engine.sv
